// ==== cp0_exc_fsm.sv ====
`timescale 1ns/1ns

module cp0_exc_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  exc_req_i,
    input  cp0_pkg::exc_req_t     exc_i,
    output logic                  exc_ack_o,
    output cp0_pkg::exc_commit_t  commit_o
);

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        COMMIT = 2'd1,
        ACK    = 2'd2
    } state_e;

    state_e            state_q;
    state_e            state_d;
    cp0_pkg::exc_req_t req_q;
    logic              ack_d;

    // Request snapshot, only taken on the IDLE to COMMIT transition
    always_ff @(posedge clk) begin
        if (state_q == IDLE && exc_req_i) begin
            req_q <= exc_i;
        end
    end

    // Next state and ack
    always_comb begin
        state_d = state_q;
        ack_d   = exc_ack_o;
        case (state_q)
            IDLE: begin
                ack_d = 1'b0;
                if (exc_req_i) begin
                    state_d = COMMIT;
                end
            end
            COMMIT: begin
                // Registers update at the end of this cycle
                state_d = ACK;
            end
            ACK: begin
                if (exc_req_i) begin
                    ack_d = 1'b1;
                end else begin
                    // Four-phase return to zero
                    ack_d   = 1'b0;
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
                ack_d   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            exc_ack_o <= 1'b0;
        end else begin
            state_q   <= state_d;
            exc_ack_o <= ack_d;
        end
    end

    // Commit carries the captured request for one cycle
    always_comb begin
        commit_o.valid    = (state_q == COMMIT);
        commit_o.eret     = (req_q.etype == cp0_pkg::EXC_ERET);
        commit_o.etype    = req_q.etype;
        commit_o.pc       = req_q.pc;
        commit_o.badvaddr = req_q.badvaddr;
        commit_o.in_slot  = req_q.in_slot;
    end

endmodule

// ==== cp0_pkg.sv ====
package cp0_pkg;

    // CP0 register addresses, {reg number, select}
    localparam logic [7:0] CP0_BADVADDR = {5'd8, 3'd0};
    localparam logic [7:0] CP0_COUNT    = {5'd9, 3'd0};
    localparam logic [7:0] CP0_COMPARE  = {5'd11, 3'd0};
    localparam logic [7:0] CP0_STATUS   = {5'd12, 3'd0};
    localparam logic [7:0] CP0_CAUSE    = {5'd13, 3'd0};
    localparam logic [7:0] CP0_EPC      = {5'd14, 3'd0};
    localparam logic [7:0] CP0_PRID     = {5'd15, 3'd0};
    localparam logic [7:0] CP0_CONFIG   = {5'd16, 3'd0};
    localparam logic [7:0] CP0_CONFIG1  = {5'd16, 3'd1};
    localparam logic [7:0] CP0_ERROREPC = {5'd30, 3'd0};

    // Exception kinds reported by the pipeline
    typedef enum logic [3:0] {
        EXC_NONE    = 4'd0,
        EXC_INTR    = 4'd1,
        EXC_ADEL_IF = 4'd2,
        EXC_ADEL_LD = 4'd3,
        EXC_ADES    = 4'd4,
        EXC_OV      = 4'd5,
        EXC_SYSC    = 4'd6,
        EXC_BP      = 4'd7,
        EXC_RI      = 4'd8,
        EXC_ERET    = 4'd9
    } exc_type_e;

    // Cause.ExcCode encodings
    localparam logic [4:0] EXCC_INT  = 5'd0;
    localparam logic [4:0] EXCC_ADEL = 5'd4;
    localparam logic [4:0] EXCC_ADES = 5'd5;
    localparam logic [4:0] EXCC_SYS  = 5'd8;
    localparam logic [4:0] EXCC_BP   = 5'd9;
    localparam logic [4:0] EXCC_RI   = 5'd10;
    localparam logic [4:0] EXCC_OV   = 5'd12;

    // Status fields
    localparam int STATUS_IE    = 0;
    localparam int STATUS_EXL   = 1;
    localparam int STATUS_ERL   = 2;
    localparam int STATUS_IM_LO = 8;
    localparam int STATUS_IM_HI = 15;
    localparam int STATUS_BEV   = 22;

    // Software interrupt bits in Cause
    localparam int CAUSE_IPS_LO = 8;
    localparam int CAUSE_IPS_HI = 9;

    // Kseg0 cacheability in Config
    localparam int CONFIG_K0_LO = 0;
    localparam int CONFIG_K0_HI = 2;

    localparam logic [31:0] ERROREPC_RESET = 32'hBFC00000;
    localparam logic [31:0] PRID_VALUE     = 32'h00018021;

    // Exception request, held stable while req is high
    typedef struct packed {
        exc_type_e   etype;
        logic [31:0] pc;
        logic [31:0] badvaddr;
        logic        in_slot;
    } exc_req_t;

    // mtc0/mfc0 access
    typedef struct packed {
        logic [7:0]  addr;
        logic        ren;
        logic        wen;
        logic [31:0] wdata;
    } csr_req_t;

    // One-cycle commit into the register block
    typedef struct packed {
        logic        valid;
        logic        eret;
        exc_type_e   etype;
        logic [31:0] pc;
        logic [31:0] badvaddr;
        logic        in_slot;
    } exc_commit_t;

endpackage

// ==== cp0_regs.sv ====
`timescale 1ns/1ns

module cp0_regs (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cp0_pkg::csr_req_t     csr_i,
    input  cp0_pkg::exc_commit_t  commit_i,
    input  logic [5:0]            intr_i,
    input  logic                  timer_irq_i,
    input  logic [31:0]           count_i,
    input  logic [31:0]           compare_i,
    output logic [31:0]           rdata_o,
    output logic                  count_wr_o,
    output logic                  compare_wr_o,
    output logic [31:0]           status_o,
    output logic [31:0]           cause_o,
    output logic [31:0]           epc_o,
    output logic [31:0]           errorepc_o,
    output logic [2:0]            k0_o,
    output logic                  intr_o
);

    // Config1: 32 TLB entries, 64B lines, 4-way I and D caches
    localparam logic [31:0] CONFIG1_VALUE = {
        1'b0, 6'd31, 3'd0, 3'd5, 3'd3, 3'd0, 3'd5, 3'd3, 7'd0
    };

    logic        status_bev;
    logic [7:0]  status_im;
    logic        status_exl;
    logic        status_ie;
    logic        cause_bd;
    logic [7:0]  cause_ip;
    logic [4:0]  cause_exccode;
    logic [31:0] badvaddr;
    logic [2:0]  config_k0;
    logic [31:0] config_w;

    logic        csr_wen;
    logic        is_exc;
    logic        is_addr_err;
    logic [4:0]  exc_code;

    // Commit takes priority over mtc0
    assign csr_wen      = csr_i.wen & ~commit_i.valid;
    assign count_wr_o   = csr_wen && (csr_i.addr == cp0_pkg::CP0_COUNT);
    assign compare_wr_o = csr_wen && (csr_i.addr == cp0_pkg::CP0_COMPARE);

    // Decode exception type
    always_comb begin
        is_exc      = 1'b1;
        is_addr_err = 1'b0;
        exc_code    = cp0_pkg::EXCC_INT;
        case (commit_i.etype)
            cp0_pkg::EXC_INTR: exc_code = cp0_pkg::EXCC_INT;
            cp0_pkg::EXC_ADEL_IF,
            cp0_pkg::EXC_ADEL_LD: begin
                exc_code    = cp0_pkg::EXCC_ADEL;
                is_addr_err = 1'b1;
            end
            cp0_pkg::EXC_ADES: begin
                exc_code    = cp0_pkg::EXCC_ADES;
                is_addr_err = 1'b1;
            end
            cp0_pkg::EXC_OV:   exc_code = cp0_pkg::EXCC_OV;
            cp0_pkg::EXC_SYSC: exc_code = cp0_pkg::EXCC_SYS;
            cp0_pkg::EXC_BP:   exc_code = cp0_pkg::EXCC_BP;
            cp0_pkg::EXC_RI:   exc_code = cp0_pkg::EXCC_RI;
            // ERET and NONE are not exceptions
            default:           is_exc = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_bev    <= 1'b1;
            status_im     <= 8'd0;
            status_exl    <= 1'b0;
            status_ie     <= 1'b0;
            cause_bd      <= 1'b0;
            cause_ip      <= 8'd0;
            cause_exccode <= 5'd0;
            epc_o         <= 32'd0;
            config_k0     <= 3'd3;
            errorepc_o    <= cp0_pkg::ERROREPC_RESET;
        end else begin
            // Hardware lines, timer shares IP7
            cause_ip[7:2] <= {intr_i[5] | timer_irq_i, intr_i[4:0]};

            if (commit_i.valid) begin
                if (is_exc) begin
                    // Nested exception keeps original EPC and BD
                    if (!status_exl) begin
                        epc_o    <= commit_i.in_slot ? commit_i.pc - 32'd4 : commit_i.pc;
                        cause_bd <= commit_i.in_slot;
                    end
                    status_exl    <= 1'b1;
                    cause_exccode <= exc_code;
                end else if (commit_i.eret) begin
                    status_exl <= 1'b0;
                end
            end else if (csr_wen) begin
                case (csr_i.addr)
                    cp0_pkg::CP0_STATUS: begin
                        status_bev <= csr_i.wdata[cp0_pkg::STATUS_BEV];
                        status_im  <= csr_i.wdata[cp0_pkg::STATUS_IM_HI:cp0_pkg::STATUS_IM_LO];
                        status_exl <= csr_i.wdata[cp0_pkg::STATUS_EXL];
                        status_ie  <= csr_i.wdata[cp0_pkg::STATUS_IE];
                    end
                    // Only software interrupts are writable
                    cp0_pkg::CP0_CAUSE: begin
                        cause_ip[1:0] <= csr_i.wdata[cp0_pkg::CAUSE_IPS_HI:cp0_pkg::CAUSE_IPS_LO];
                    end
                    cp0_pkg::CP0_EPC:      epc_o      <= csr_i.wdata;
                    cp0_pkg::CP0_ERROREPC: errorepc_o <= csr_i.wdata;
                    cp0_pkg::CP0_CONFIG: begin
                        config_k0 <= csr_i.wdata[cp0_pkg::CONFIG_K0_HI:cp0_pkg::CONFIG_K0_LO];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Faulting address
    always_ff @(posedge clk) begin
        if (commit_i.valid && is_addr_err) begin
            badvaddr <= commit_i.badvaddr;
        end else if (csr_wen && csr_i.addr == cp0_pkg::CP0_BADVADDR) begin
            badvaddr <= csr_i.wdata;
        end
    end

    // ERL is not implemented and reads 0
    assign status_o = {9'd0, status_bev, 6'd0, status_im, 5'd0, 1'b0, status_exl, status_ie};
    assign cause_o  = {cause_bd, 15'd0, cause_ip, 1'b0, cause_exccode, 2'd0};

    // Config: M set, MT standard TLB
    assign config_w = {1'b1, 23'd0, 1'b1, 4'd0, config_k0};
    assign k0_o     = config_w[cp0_pkg::CONFIG_K0_HI:cp0_pkg::CONFIG_K0_LO];

    // mfc0 read, wdata bypass when not reading
    always_comb begin
        if (csr_i.ren) begin
            case (csr_i.addr)
                cp0_pkg::CP0_BADVADDR: rdata_o = badvaddr;
                cp0_pkg::CP0_COUNT:    rdata_o = count_i;
                cp0_pkg::CP0_COMPARE:  rdata_o = compare_i;
                cp0_pkg::CP0_STATUS:   rdata_o = status_o;
                cp0_pkg::CP0_CAUSE:    rdata_o = cause_o;
                cp0_pkg::CP0_EPC:      rdata_o = epc_o;
                cp0_pkg::CP0_PRID:     rdata_o = cp0_pkg::PRID_VALUE;
                cp0_pkg::CP0_CONFIG:   rdata_o = config_w;
                cp0_pkg::CP0_CONFIG1:  rdata_o = CONFIG1_VALUE;
                cp0_pkg::CP0_ERROREPC: rdata_o = errorepc_o;
                default:               rdata_o = 32'd0;
            endcase
        end else begin
            rdata_o = csr_i.wdata;
        end
    end

    // Pending and enabled, outside exception and error level
    assign intr_o = ((cause_o[15:8] & status_o[cp0_pkg::STATUS_IM_HI:cp0_pkg::STATUS_IM_LO])
                     != 8'd0)
                    && status_o[cp0_pkg::STATUS_IE]
                    && !status_o[cp0_pkg::STATUS_EXL]
                    && !status_o[cp0_pkg::STATUS_ERL];

endmodule

// ==== cp0_tb.sv ====
`timescale 1ns/1ns

module cp0_tb;

    logic              clk;
    logic              rst_n;
    cp0_pkg::csr_req_t csr;
    logic              exc_req;
    cp0_pkg::exc_req_t exc;
    logic [5:0]        intr;
    logic [31:0]       rdata;
    logic              exc_ack;
    logic [31:0]       status;
    logic [31:0]       cause;
    logic [31:0]       epc;
    logic [31:0]       errorepc;
    logic [2:0]        k0;
    logic              irq;

    int checks   = 0;
    int errors   = 0;
    int g_checks = 0;
    int g_errors = 0;
    int group_id = 0;
    int cycles   = 0;
    int limit    = 200;
    int nlines   = 0;
    int fd;
    int code;

    logic [7:0]        op;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       c;
    logic [31:0]       d;
    logic [31:0]       got;
    logic [8*160-1:0]  skip;

    tb_clk_gen #(
        .PERIOD_NS (8)
    ) u_clk_gen (
        .clk_o (clk)
    );

    cp0_top #(
        .COUNT_DIV  (2)
    ) u_cp0_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_i      (csr),
        .exc_req_i  (exc_req),
        .exc_i      (exc),
        .intr_i     (intr),
        .rdata_o    (rdata),
        .exc_ack_o  (exc_ack),
        .status_o   (status),
        .cause_o    (cause),
        .epc_o      (epc),
        .errorepc_o (errorepc),
        .k0_o       (k0),
        .intr_o     (irq)
    );

    // Watchdog limit is sized from the data file
    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic string test_name(input int id);
        case (id)
            0: return "reset_outputs";
            1: return "reset_values";
            2: return "csr_access";
            3: return "exc_commit";
            4: return "nesting_eret";
            5: return "interrupt";
            6: return "timer";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got_v,
                             input logic [31:0] exp_v);
        checks++;
        g_checks++;
        if (got_v !== exp_v) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got_v, exp_v);
            errors++;
            g_errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        errors++;
        g_errors++;
    endtask

    task automatic finish_group();
        $display("test %0d %s: %0d checks, %0d errors", group_id, test_name(group_id),
                 g_checks, g_errors);
        g_checks = 0;
        g_errors = 0;
    endtask

    // Direct output ports must agree with the value read over mfc0
    task automatic mirror_output_check(input logic [7:0] addr, input logic [31:0] exp_v);
        case (addr)
            cp0_pkg::CP0_STATUS:   check_val("status_o", status, exp_v);
            cp0_pkg::CP0_CAUSE:    check_val("cause_o", cause, exp_v);
            cp0_pkg::CP0_EPC:      check_val("epc_o", epc, exp_v);
            cp0_pkg::CP0_ERROREPC: check_val("errorepc_o", errorepc, exp_v);
            cp0_pkg::CP0_CONFIG:   check_val("k0_o", {29'd0, k0}, {29'd0, exp_v[2:0]});
            default: ;
        endcase
    endtask

    // mtc0 write lands on the next rising edge
    task automatic csr_write(input logic [7:0] addr, input logic [31:0] data);
        csr.addr  = addr;
        csr.wdata = data;
        csr.wen   = 1'b1;
        @(negedge clk);
        csr.wen   = 1'b0;
    endtask

    // mfc0 read sampled a full cycle after the address is driven
    task automatic csr_read(input logic [7:0] addr, output logic [31:0] data);
        csr.addr = addr;
        csr.ren  = 1'b1;
        @(negedge clk);
        data     = rdata;
        csr.ren  = 1'b0;
    endtask

    // Four-phase handshake with the exception FSM
    task automatic run_exception(input logic [3:0] etype, input logic [31:0] pc,
                                 input logic [31:0] bva, input logic slot);
        int n;
        exc.etype    = cp0_pkg::exc_type_e'(etype);
        exc.pc       = pc;
        exc.badvaddr = bva;
        exc.in_slot  = slot;
        exc_req      = 1'b1;
        n = 0;
        while (exc_ack !== 1'b1 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (exc_ack !== 1'b1) begin
            report_error($sformatf("exc_ack_o never rose within 10 cycles (type %0d)", etype));
        end
        exc_req = 1'b0;
        n = 0;
        while (exc_ack !== 1'b0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (exc_ack !== 1'b0) begin
            report_error("exc_ack_o stayed high after exc_req_i was dropped");
        end
    endtask

    task automatic wait_intr(input int max_cycles);
        int n;
        n = 0;
        while (irq !== 1'b1 && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        checks++;
        g_checks++;
        if (irq !== 1'b1) begin
            report_error($sformatf("intr_o did not rise within %0d cycles", max_cycles));
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        csr     = '0;
        exc_req = 1'b0;
        exc     = '0;
        intr    = '0;
        fd = $fopen("cp0_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open cp0_testdata.txt");
            $display("=== FAIL ===");
            $finish;
        end else begin
            // First pass only counts lines
            while (!$feof(fd)) begin
                if ($fgets(skip, fd) != 0) begin
                    nlines++;
                end
            end
            $fclose(fd);
            limit = 40 * nlines + 200;
            fd = $fopen("cp0_testdata.txt", "r");

            repeat (3) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            check_val("exc_ack_o", {31'd0, exc_ack}, 32'd0);
            check_val("intr_o", {31'd0, irq}, 32'd0);
            finish_group();

            // Every operation starts and ends on a falling edge
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) begin
                    break;
                end
                case (op)
                    "#": code = $fgets(skip, fd);
                    "S": begin
                        code = $fscanf(fd, "%h", a);
                        if (group_id > 0) begin
                            finish_group();
                        end
                        group_id = int'(a);
                    end
                    "W": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        csr_write(a[7:0], b);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        csr_read(a[7:0], got);
                        check_val($sformatf("rdata_o[%02h]", a[7:0]), got, b);
                        mirror_output_check(a[7:0], b);
                    end
                    "C": begin
                        code = $fscanf(fd, "%h %h", a, b);
                        csr_read(a[7:0], got);
                        // Anything at or above the minimum counts as a match
                        check_val($sformatf("rdata_o[%02h] min", a[7:0]),
                                  (got >= b) ? b : got, b);
                    end
                    "B": begin
                        code = $fscanf(fd, "%h", a);
                        csr.wdata = a;
                        @(negedge clk);
                        check_val("rdata_o bypass", rdata, a);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                        run_exception(a[3:0], b, c, d[0]);
                    end
                    "I": begin
                        code = $fscanf(fd, "%h", a);
                        intr = a[5:0];
                    end
                    "Q": begin
                        code = $fscanf(fd, "%h", a);
                        @(negedge clk);
                        check_val("intr_o", {31'd0, irq}, {31'd0, a[0]});
                    end
                    "T": begin
                        code = $fscanf(fd, "%h", a);
                        wait_intr(int'(a));
                    end
                    default: report_error($sformatf("unknown operation %c in test data", op));
                endcase
            end
            $fclose(fd);
            if (group_id > 0) begin
                finish_group();
            end

            $display("Summary: %0d checks, %0d errors", checks, errors);
            if (errors == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

// ==== cp0_testdata.txt ====
# op and hex fields: S test | W addr data | R addr expected | C addr minimum | B wdata
# E etype pc badvaddr in_slot | I intr_i | Q expected intr_o | T max cycles for intr_o
S 1
R 60 00400000
R 68 00000000
R 70 00000000
R 80 80000083
R 81 3E2B1580
R 78 00018021
R F0 BFC00000
R 58 00000000
S 2
W 60 FFFFFFFF
R 60 0040FF03
W 60 00400000
R 60 00400000
W 68 FFFFFFFF
R 68 00000300
W 68 00000000
W 80 FFFFFFFF
R 80 80000087
W 70 12345678
R 70 12345678
W 40 DEADBEEF
R 40 DEADBEEF
W F0 A5A5A5A4
R F0 A5A5A5A4
W 78 FFFFFFFF
R 78 00018021
R 20 00000000
B CAFEF00D
S 3
E 6 80001000 00000000 0
R 70 80001000
R 68 00000020
R 60 00400002
E 9 00000000 00000000 0
E 3 80002004 00000123 1
R 70 80002000
R 68 80000010
R 40 00000123
E 9 00000000 00000000 0
E 4 80003000 0000FFFD 0
R 68 00000014
R 40 0000FFFD
E 9 00000000 00000000 0
E 5 80004008 11111111 1
R 70 80004004
R 68 80000030
R 40 0000FFFD
E 9 00000000 00000000 0
S 4
E 6 80006000 00000000 1
E 8 80007000 00000000 0
R 70 80005FFC
R 68 80000028
R 60 00400002
E 9 00000000 00000000 0
R 60 00400000
S 5
I 01
Q 0
W 60 00400401
Q 1
W 60 00400403
Q 0
W 60 00400400
Q 0
I 00
W 68 00000100
W 60 00400101
Q 1
W 68 00000000
Q 0
I 20
W 60 00408001
Q 1
I 00
Q 0
S 6
W 58 00000014
W 48 00000000
Q 0
T 3C
R 68 80008028
C 48 00000014
W 58 00001000
Q 0
R 68 80000028

// ==== cp0_timer.sv ====
`timescale 1ns/1ns

module cp0_timer #(
    parameter int COUNT_DIV = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        count_wr_i,
    input  logic        compare_wr_i,
    input  logic [31:0] wdata_i,
    output logic [31:0] count_o,
    output logic [31:0] compare_o,
    output logic        timer_irq_o
);

    // Divider needs at least one bit even when COUNT_DIV is 1
    localparam int DIV_W = (COUNT_DIV > 1) ? $clog2(COUNT_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             div_tick;
    logic             timer_hit;

    // Count advances on the last clock of each divider period
    assign div_tick = (div_cnt == DIV_W'(COUNT_DIV - 1));

    // Compare of zero never fires
    assign timer_hit = (compare_o != 32'd0) && (count_o == compare_o);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            count_o <= 32'd0;
        end else if (count_wr_i) begin
            // Load restarts the divider period
            div_cnt <= '0;
            count_o <= wdata_i;
        end else if (div_tick) begin
            div_cnt <= '0;
            count_o <= count_o + 32'd1;
        end else begin
            div_cnt <= div_cnt + DIV_W'(1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            compare_o   <= 32'd0;
            timer_irq_o <= 1'b0;
        end else if (compare_wr_i) begin
            // Rewriting Compare acknowledges the timer
            compare_o   <= wdata_i;
            timer_irq_o <= 1'b0;
        end else if (timer_hit) begin
            // Sticky until the next Compare write
            timer_irq_o <= 1'b1;
        end
    end

endmodule

// ==== cp0_top.sv ====
`timescale 1ns/1ns

module cp0_top #(
    parameter int COUNT_DIV = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  cp0_pkg::csr_req_t  csr_i,
    input  logic               exc_req_i,
    input  cp0_pkg::exc_req_t  exc_i,
    input  logic [5:0]         intr_i,
    output logic [31:0]        rdata_o,
    output logic               exc_ack_o,
    output logic [31:0]        status_o,
    output logic [31:0]        cause_o,
    output logic [31:0]        epc_o,
    output logic [31:0]        errorepc_o,
    output logic [2:0]         k0_o,
    output logic               intr_o
);

    cp0_pkg::exc_commit_t commit;
    logic [31:0]          count;
    logic [31:0]          compare;
    logic                 timer_irq;
    logic                 count_wr;
    logic                 compare_wr;

    // Count/Compare
    cp0_timer #(
        .COUNT_DIV    (COUNT_DIV)
    ) u_cp0_timer (
        .clk          (clk),
        .rst_n        (rst_n),
        .count_wr_i   (count_wr),
        .compare_wr_i (compare_wr),
        .wdata_i      (csr_i.wdata),
        .count_o      (count),
        .compare_o    (compare),
        .timer_irq_o  (timer_irq)
    );

    // Exception handshake
    cp0_exc_fsm u_cp0_exc_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .exc_req_i    (exc_req_i),
        .exc_i        (exc_i),
        .exc_ack_o    (exc_ack_o),
        .commit_o     (commit)
    );

    cp0_regs u_cp0_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_i        (csr_i),
        .commit_i     (commit),
        .intr_i       (intr_i),
        .timer_irq_i  (timer_irq),
        .count_i      (count),
        .compare_i    (compare),
        .rdata_o      (rdata_o),
        .count_wr_o   (count_wr),
        .compare_wr_o (compare_wr),
        .status_o     (status_o),
        .cause_o      (cause_o),
        .epc_o        (epc_o),
        .errorepc_o   (errorepc_o),
        .k0_o         (k0_o),
        .intr_o       (intr_o)
    );

endmodule

// ==== project.f ====
cp0_pkg.sv
cp0_timer.sv
cp0_exc_fsm.sv
cp0_regs.sv
cp0_top.sv
tb_clk_gen.sv
cp0_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cp0_tb -f project.f -o cp0_sim
out=$(./obj_dir/cp0_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);

    // Starts low, first rising edge at half a period
    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule
